/* Bender.yml */
package:
  name: udp_echo

sources:
  - udp_echo_pkg.sv
  - udp_port_filter.sv
  - udp_payload_fifo.sv
  - udp_reply_builder.sv
  - udp_echo_top.sv
  - target: test
    files:
      - udp_echo_checker.sv
      - tb_udp_echo.sv

/* project.f */
udp_echo_pkg.sv
udp_port_filter.sv
udp_payload_fifo.sv
udp_reply_builder.sv
udp_echo_top.sv
udp_echo_checker.sv
tb_udp_echo.sv

/* tb_udp_echo.sv */
// Testbench for the UDP echo core that drives a table of frames into the DUT
// under random output back-pressure while udp_echo_checker compares the outputs.
`timescale 1ns/10ps

module tb_udp_echo;
    import udp_echo_pkg::*;

    localparam udp_port_t ECHO_PORT   = 16'd1234;
    localparam int        FIFO_DEPTH  = 16;
    localparam int        NUM_FRAMES  = 8;
    localparam int        WAIT_LIMIT  = 500;
    localparam int        DRAIN_LIMIT = 4000;

    // One frame of stimulus and whether it should be echoed
    typedef struct packed {
        ip_addr_t  src_ip;
        ip_addr_t  dst_ip;
        udp_port_t src_port;
        udp_port_t dst_port;
        int        len;
        logic      user_last;
        logic      gaps;
        logic      exp_echo;
    } frame_t;

    logic           clk = 1'b0;
    logic           rst;
    udp_rx_hdr_t    rx_hdr;
    logic           rx_hdr_valid;
    logic           rx_hdr_ready;
    payload_beat_t  rx_beat;
    logic           rx_beat_valid;
    logic           rx_beat_ready;
    udp_reply_hdr_t tx_hdr;
    logic           tx_hdr_valid;
    logic           tx_hdr_ready;
    payload_beat_t  tx_beat;
    logic           tx_beat_valid;
    logic           tx_beat_ready;
    byte_t          led;
    logic           final_check;

    frame_t frames [NUM_FRAMES];
    bit     timed_out;
    bit     drained;
    int     seed;
    int     count_errors;
    int     exp_hdrs;
    int     exp_beats;
    int     chk_errors;
    int     chk_missing;
    int     chk_hdrs;
    int     chk_beats;
    int     chk_pending;

    always #4 clk = ~clk;

    udp_echo_top #(
        .ECHO_PORT  (ECHO_PORT),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_udp_echo_top (
        .clk           (clk),
        .rst           (rst),
        .rx_hdr        (rx_hdr),
        .rx_hdr_valid  (rx_hdr_valid),
        .rx_hdr_ready  (rx_hdr_ready),
        .rx_beat       (rx_beat),
        .rx_beat_valid (rx_beat_valid),
        .rx_beat_ready (rx_beat_ready),
        .tx_hdr        (tx_hdr),
        .tx_hdr_valid  (tx_hdr_valid),
        .tx_hdr_ready  (tx_hdr_ready),
        .tx_beat       (tx_beat),
        .tx_beat_valid (tx_beat_valid),
        .tx_beat_ready (tx_beat_ready),
        .led           (led)
    );

    udp_echo_checker #(
        .ECHO_PORT (ECHO_PORT)
    ) u_udp_echo_checker (
        .clk           (clk),
        .rst           (rst),
        .rx_hdr        (rx_hdr),
        .rx_hdr_valid  (rx_hdr_valid),
        .rx_hdr_ready  (rx_hdr_ready),
        .rx_beat       (rx_beat),
        .rx_beat_valid (rx_beat_valid),
        .rx_beat_ready (rx_beat_ready),
        .tx_hdr        (tx_hdr),
        .tx_hdr_valid  (tx_hdr_valid),
        .tx_hdr_ready  (tx_hdr_ready),
        .tx_beat       (tx_beat),
        .tx_beat_valid (tx_beat_valid),
        .tx_beat_ready (tx_beat_ready),
        .led           (led),
        .final_check   (final_check),
        .error_count   (chk_errors),
        .missing_count (chk_missing),
        .hdr_count     (chk_hdrs),
        .beat_count    (chk_beats),
        .pending       (chk_pending)
    );

    // Random back-pressure on both reply outputs
    // Payload side is stalled most cycles so the 24-byte frame fills the FIFO
    always @(posedge clk) begin
        if (rst) begin
            tx_hdr_ready  <= 1'b0;
            tx_beat_ready <= 1'b0;
        end else begin
            tx_hdr_ready  <= ($urandom % 4) != 0;
            tx_beat_ready <= ($urandom % 5) == 0;
        end
    end

    function automatic void load_frames();
        // src_ip, dst_ip, src_port, dst_port, len, user_last, gaps, exp_echo
        frames[0] = '{32'hc0a8_0a01, 32'hc0a8_0a64, 16'd40001, ECHO_PORT, 4, 1'b0, 1'b0, 1'b1};
        frames[1] = '{32'hc0a8_0a02, 32'hc0a8_0a64, 16'd40002, 16'd80, 6, 1'b0, 1'b1, 1'b0};
        frames[2] = '{32'h0a00_0005, 32'hc0a8_0a64, 16'd53, ECHO_PORT, 1, 1'b1, 1'b0, 1'b1};
        frames[3] = '{32'hac10_2233, 32'hc0a8_0a64, 16'd61000, ECHO_PORT, 24, 1'b0, 1'b0, 1'b1};
        frames[4] = '{32'hc0a8_0a03, 32'hc0a8_0a64, 16'd40003, 16'd1235, 3, 1'b1, 1'b1, 1'b0};
        frames[5] = '{32'h0a01_0203, 32'hc0a8_0a64, 16'd1234, ECHO_PORT, 9, 1'b1, 1'b1, 1'b1};
        frames[6] = '{32'hc0a8_01fe, 32'hc0a8_0a64, 16'd9999, ECHO_PORT, 17, 1'b0, 1'b0, 1'b1};
        frames[7] = '{32'hc0a8_0a04, 32'hc0a8_0a64, 16'd40004, 16'd4660, 5, 1'b0, 1'b0, 1'b0};
    endfunction

    function automatic byte_t payload_byte(input int idx, input int pos);
        return byte_t'(idx * 32 + pos * 3 + 1);
    endfunction

    // Waits for the header or beat handshake to complete
    task automatic wait_for_accept(input bit beat_side, output bit ok);
        int   cycles;
        logic ready;
        cycles = 0;
        do begin
            @(posedge clk);
            ready = beat_side ? rx_beat_ready : rx_hdr_ready;
            cycles++;
        end while (!ready && cycles < WAIT_LIMIT);
        ok = ready;
    endtask

    task automatic send_frame(input int idx);
        udp_rx_hdr_t   hdr;
        payload_beat_t beat;
        int            gap;
        int            pos;
        bit            ok;
        hdr.source_ip   = frames[idx].src_ip;
        hdr.dest_ip     = frames[idx].dst_ip;
        hdr.source_port = frames[idx].src_port;
        hdr.dest_port   = frames[idx].dst_port;
        hdr.length      = 16'(8 + frames[idx].len);
        hdr.checksum    = 16'h5a00 + 16'(idx);
        rx_hdr       <= hdr;
        rx_hdr_valid <= 1'b1;
        wait_for_accept(1'b0, ok);
        rx_hdr_valid <= 1'b0;
        if (!ok) begin
            $display("Timeout: header of frame %0d was never accepted", idx);
            timed_out = 1'b1;
            return;
        end
        for (pos = 0; pos < frames[idx].len; pos++) begin
            if (frames[idx].gaps) begin
                gap = $urandom % 4;
                rx_beat_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            beat.data = payload_byte(idx, pos);
            beat.last = (pos == frames[idx].len - 1);
            beat.user = beat.last && frames[idx].user_last;
            rx_beat       <= beat;
            rx_beat_valid <= 1'b1;
            wait_for_accept(1'b1, ok);
            if (!ok) begin
                $display("Timeout: beat %0d of frame %0d was never accepted", pos, idx);
                rx_beat_valid <= 1'b0;
                timed_out = 1'b1;
                return;
            end
        end
        rx_beat_valid <= 1'b0;
    endtask

    task automatic wait_drain(output bit ok);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (chk_pending != 0 && cycles < DRAIN_LIMIT);
        ok = (chk_pending == 0);
    endtask

    initial begin
        seed          = $urandom(32'h72b7397a);
        rst           = 1'b1;
        rx_hdr        = '0;
        rx_hdr_valid  = 1'b0;
        rx_beat       = '0;
        rx_beat_valid = 1'b0;
        tx_hdr_ready  = 1'b0;
        tx_beat_ready = 1'b0;
        final_check   = 1'b0;
        timed_out     = 1'b0;
        count_errors  = 0;
        exp_hdrs      = 0;
        exp_beats     = 0;
        load_frames();
        for (int i = 0; i < NUM_FRAMES; i++) begin
            if (frames[i].exp_echo) begin
                exp_hdrs++;
                exp_beats += frames[i].len;
            end
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < NUM_FRAMES && !timed_out; i++) begin
            send_frame(i);
        end
        if (!timed_out) begin
            wait_drain(drained);
            if (!drained) begin
                $display("Timeout: echoed output did not drain");
                timed_out = 1'b1;
            end
        end
        // Idle time so stray extra outputs are still seen
        repeat (20) @(posedge clk);
        final_check <= 1'b1;
        repeat (3) @(posedge clk);
        if (chk_hdrs != exp_hdrs) begin
            $display("[ERROR] %0t reply header count expected %0d actual %0d",
                     $time, exp_hdrs, chk_hdrs);
            count_errors++;
        end
        if (chk_beats != exp_beats) begin
            $display("[ERROR] %0t output beat count expected %0d actual %0d",
                     $time, exp_beats, chk_beats);
            count_errors++;
        end
        $display("Errors: %0d mismatches, %0d missing outputs, %0d count errors, %0d timeouts",
                 chk_errors, chk_missing, count_errors, timed_out);
        if (timed_out || chk_errors != 0 || chk_missing != 0 || count_errors != 0) begin
            $display("SIMULATION FAILED");
        end else begin
            $display("SIMULATION PASSED");
        end
        $finish;
    end

endmodule

/* udp_echo_checker.sv */
// Testbench checker for the UDP echo core: predicts replies from accepted input
// transfers and compares them with the output transfers and the LED value.
`timescale 1ns/10ps

module udp_echo_checker #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT = udp_echo_pkg::DEFAULT_ECHO_PORT
) (
    input  logic                         clk,
    input  logic                         rst,
    input  udp_echo_pkg::udp_rx_hdr_t    rx_hdr,
    input  logic                         rx_hdr_valid,
    input  logic                         rx_hdr_ready,
    input  udp_echo_pkg::payload_beat_t  rx_beat,
    input  logic                         rx_beat_valid,
    input  logic                         rx_beat_ready,
    input  udp_echo_pkg::udp_reply_hdr_t tx_hdr,
    input  logic                         tx_hdr_valid,
    input  logic                         tx_hdr_ready,
    input  udp_echo_pkg::payload_beat_t  tx_beat,
    input  logic                         tx_beat_valid,
    input  logic                         tx_beat_ready,
    input  udp_echo_pkg::byte_t          led,
    input  logic                         final_check,
    output int                           error_count,
    output int                           missing_count,
    output int                           hdr_count,
    output int                           beat_count,
    output int                           pending
);
    import udp_echo_pkg::*;

    udp_reply_hdr_t exp_hdr_q[$];
    payload_beat_t  exp_beat_q[$];

    int    errors      = 0;
    int    missing     = 0;
    int    hdrs        = 0;
    int    beats       = 0;
    logic  rst_prev    = 1'b0;
    logic  in_echo     = 1'b0;
    logic  out_first   = 1'b1;
    logic  led_pending = 1'b0;
    logic  final_done  = 1'b0;
    byte_t frame_first = '0;
    byte_t led_exp     = '0;

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (exp !== act) begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    always @(posedge clk) begin : sample
        udp_reply_hdr_t pred;
        udp_reply_hdr_t exp_hdr;
        payload_beat_t  exp_beat;
        // Outputs must be quiet in reset and on the first edge after it
        if (rst_prev) begin
            compare_value("tx_hdr_valid", 32'd0, {31'd0, tx_hdr_valid});
            compare_value("tx_beat_valid", 32'd0, {31'd0, tx_beat_valid});
            compare_value("led", 32'd0, {24'd0, led});
        end
        rst_prev = rst;
        if (rst) begin
            in_echo     = 1'b0;
            out_first   = 1'b1;
            led_pending = 1'b0;
            led_exp     = '0;
        end else begin
            if (led_pending) begin
                compare_value("led", {24'd0, led_exp}, {24'd0, led});
                led_pending = 1'b0;
            end
            if (rx_beat_valid && rx_beat_ready && in_echo) begin
                exp_beat_q.push_back(rx_beat);
                in_echo = !rx_beat.last;
            end
            // Reply goes back to the sender, ports swapped, length kept
            if (rx_hdr_valid && rx_hdr_ready && rx_hdr.dest_port == ECHO_PORT) begin
                pred.dest_ip     = rx_hdr.source_ip;
                pred.source_port = rx_hdr.dest_port;
                pred.dest_port   = rx_hdr.source_port;
                pred.length      = rx_hdr.length;
                exp_hdr_q.push_back(pred);
                in_echo = 1'b1;
            end
            if (tx_hdr_valid && tx_hdr_ready) begin
                hdrs++;
                if (exp_hdr_q.size() == 0) begin
                    $display("At %0t a reply header came out with no echoed frame for it", $time);
                    errors++;
                end else begin
                    exp_hdr = exp_hdr_q.pop_front();
                    compare_value("tx_hdr.dest_ip", exp_hdr.dest_ip, tx_hdr.dest_ip);
                    compare_value("tx_hdr.source_port", {16'd0, exp_hdr.source_port},
                                  {16'd0, tx_hdr.source_port});
                    compare_value("tx_hdr.dest_port", {16'd0, exp_hdr.dest_port},
                                  {16'd0, tx_hdr.dest_port});
                    compare_value("tx_hdr.length", {16'd0, exp_hdr.length},
                                  {16'd0, tx_hdr.length});
                end
            end
            if (tx_beat_valid && tx_beat_ready) begin
                beats++;
                if (exp_beat_q.size() == 0) begin
                    $display("At %0t a payload beat came out that was never echoed", $time);
                    errors++;
                end else begin
                    exp_beat = exp_beat_q.pop_front();
                    compare_value("tx_beat.data", {24'd0, exp_beat.data}, {24'd0, tx_beat.data});
                    compare_value("tx_beat.last", {31'd0, exp_beat.last}, {31'd0, tx_beat.last});
                    compare_value("tx_beat.user", {31'd0, exp_beat.user}, {31'd0, tx_beat.user});
                    if (out_first) begin
                        frame_first = exp_beat.data;
                    end
                    out_first = exp_beat.last;
                    // LED shows the frame's first byte once the frame is out
                    if (exp_beat.last) begin
                        led_exp     = frame_first;
                        led_pending = 1'b1;
                    end
                end
            end
            if (final_check && !final_done) begin
                final_done = 1'b1;
                compare_value("led", {24'd0, led_exp}, {24'd0, led});
                foreach (exp_hdr_q[i]) begin
                    $display("Reply header to %h never came out", exp_hdr_q[i].dest_ip);
                end
                if (exp_beat_q.size() != 0) begin
                    $display("%0d echoed payload beats never came out", exp_beat_q.size());
                end
                missing = exp_hdr_q.size() + exp_beat_q.size();
            end
        end
        error_count   <= errors;
        missing_count <= missing;
        hdr_count     <= hdrs;
        beat_count    <= beats;
        pending       <= exp_hdr_q.size() + exp_beat_q.size();
    end

endmodule

/* udp_echo_pkg.sv */
// Shared field types, header structs and the payload beat for the UDP echo core.
// Imported by every RTL module that handles headers, beats or filter state.
package udp_echo_pkg;

    // One payload byte on the byte-wide stream
    typedef logic [7:0] byte_t;

    // IPv4 address
    typedef logic [31:0] ip_addr_t;

    // UDP port number
    typedef logic [15:0] udp_port_t;

    // UDP length field, also used for the checksum word
    typedef logic [15:0] udp_len_t;

    // Decoded header of a received UDP frame, 128 bits
    typedef struct packed {
        ip_addr_t  source_ip;
        ip_addr_t  dest_ip;
        udp_port_t source_port;
        udp_port_t dest_port;
        udp_len_t  length;
        udp_len_t  checksum;
    } udp_rx_hdr_t;

    // Reply header handed to the transmit stack, 80 bits
    // TTL, DSCP/ECN, source IP and checksum are added downstream
    typedef struct packed {
        ip_addr_t  dest_ip;
        udp_port_t source_port;
        udp_port_t dest_port;
        udp_len_t  length;
    } udp_reply_hdr_t;

    // One beat of the payload stream, 10 bits
    typedef struct packed {
        byte_t data;
        // Final byte of the frame
        logic  last;
        // Error mark from the receive side, carried through untouched
        logic  user;
    } payload_beat_t;

    // Per-frame decision held by the port filter
    typedef enum logic [1:0] {
        FILTER_IDLE = 2'd0,
        FILTER_PASS = 2'd1,
        FILTER_DROP = 2'd2
    } filter_state_t;

    // Frames sent to this port are echoed
    localparam udp_port_t DEFAULT_ECHO_PORT = 16'd1234;

endpackage

/* udp_echo_top.sv */
// Top level of the UDP echo core: port filter, payload FIFO and reply builder.
// Set ECHO_PORT and FIFO_DEPTH here; they are passed down to the blocks.
`timescale 1ns/10ps

module udp_echo_top #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT  = udp_echo_pkg::DEFAULT_ECHO_PORT,
    parameter int                      FIFO_DEPTH = 16
) (
    input  logic                         clk,
    input  logic                         rst,

    // Received UDP frame
    input  udp_echo_pkg::udp_rx_hdr_t    rx_hdr,
    input  logic                         rx_hdr_valid,
    output logic                         rx_hdr_ready,
    input  udp_echo_pkg::payload_beat_t  rx_beat,
    input  logic                         rx_beat_valid,
    output logic                         rx_beat_ready,

    // Echoed UDP frame
    output udp_echo_pkg::udp_reply_hdr_t tx_hdr,
    output logic                         tx_hdr_valid,
    input  logic                         tx_hdr_ready,
    output udp_echo_pkg::payload_beat_t  tx_beat,
    output logic                         tx_beat_valid,
    input  logic                         tx_beat_ready,

    output udp_echo_pkg::byte_t          led
);
    import udp_echo_pkg::*;

    logic          echo_hdr_valid;
    logic          echo_hdr_ready;
    payload_beat_t wr_beat;
    logic          wr_valid;
    logic          wr_ready;

    udp_port_filter #(
        .ECHO_PORT (ECHO_PORT)
    ) u_udp_port_filter (
        .clk            (clk),
        .rst            (rst),
        .rx_hdr         (rx_hdr),
        .rx_hdr_valid   (rx_hdr_valid),
        .rx_hdr_ready   (rx_hdr_ready),
        .rx_beat        (rx_beat),
        .rx_beat_valid  (rx_beat_valid),
        .rx_beat_ready  (rx_beat_ready),
        .echo_hdr_valid (echo_hdr_valid),
        .echo_hdr_ready (echo_hdr_ready),
        .wr_beat        (wr_beat),
        .wr_valid       (wr_valid),
        .wr_ready       (wr_ready)
    );

    // FIFO read side drives the payload outputs directly
    udp_payload_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_udp_payload_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_beat  (wr_beat),
        .wr_valid (wr_valid),
        .wr_ready (wr_ready),
        .rd_beat  (tx_beat),
        .rd_valid (tx_beat_valid),
        .rd_ready (tx_beat_ready)
    );

    udp_reply_builder u_udp_reply_builder (
        .clk            (clk),
        .rst            (rst),
        .rx_hdr         (rx_hdr),
        .echo_hdr_valid (echo_hdr_valid),
        .echo_hdr_ready (echo_hdr_ready),
        .tx_hdr         (tx_hdr),
        .tx_hdr_valid   (tx_hdr_valid),
        .tx_hdr_ready   (tx_hdr_ready),
        .rd_beat        (tx_beat),
        .rd_valid       (tx_beat_valid),
        .rd_ready       (tx_beat_ready),
        .led            (led)
    );

endmodule

/* udp_payload_fifo.sv */
// Synchronous FIFO for echoed payload beats with a registered output stage.
// A write into an empty FIFO bypasses the memory, so rd_valid rises one cycle later.
`timescale 1ns/10ps

module udp_payload_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                        clk,
    input  logic                        rst,

    // Write side
    input  udp_echo_pkg::payload_beat_t wr_beat,
    input  logic                        wr_valid,
    output logic                        wr_ready,

    // Read side
    output udp_echo_pkg::payload_beat_t rd_beat,
    output logic                        rd_valid,
    input  logic                        rd_ready
);
    import udp_echo_pkg::*;

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    // Pointers carry one extra wrap bit to tell full from empty
    typedef logic [ADDR_W:0] ptr_t;

    payload_beat_t mem [FIFO_DEPTH];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    logic mem_empty;
    logic mem_full;
    logic wr_fire;
    logic out_free;
    logic mem_pop;
    logic bypass;
    logic mem_push;

    assign mem_empty = (wr_ptr == rd_ptr);
    assign mem_full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                       (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    assign wr_ready = !mem_full;
    assign wr_fire  = wr_valid && wr_ready;

    // Output register can take a new beat this edge
    assign out_free = !rd_valid || rd_ready;

    // Memory feeds the output first to keep order
    assign mem_pop  = out_free && !mem_empty;
    assign bypass   = out_free && mem_empty && wr_fire;
    assign mem_push = wr_fire && !bypass;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (mem_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (mem_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (out_free) begin
                rd_valid <= mem_pop || bypass;
            end
        end
    end

    // Storage and output data
    always_ff @(posedge clk) begin
        if (mem_push) begin
            mem[wr_ptr[ADDR_W-1:0]] <= wr_beat;
        end
        if (mem_pop) begin
            rd_beat <= mem[rd_ptr[ADDR_W-1:0]];
        end else if (bypass) begin
            rd_beat <= wr_beat;
        end
    end

endmodule

/* udp_port_filter.sv */
// Input side of the echo core: takes each header, decides echo or drop by port,
// then forwards the payload to the FIFO or swallows it until the last beat.
`timescale 1ns/10ps

module udp_port_filter #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT = udp_echo_pkg::DEFAULT_ECHO_PORT
) (
    input  logic                        clk,
    input  logic                        rst,

    // Received header
    input  udp_echo_pkg::udp_rx_hdr_t   rx_hdr,
    input  logic                        rx_hdr_valid,
    output logic                        rx_hdr_ready,

    // Received payload
    input  udp_echo_pkg::payload_beat_t rx_beat,
    input  logic                        rx_beat_valid,
    output logic                        rx_beat_ready,

    // Header handshake towards the reply builder
    output logic                        echo_hdr_valid,
    input  logic                        echo_hdr_ready,

    // Payload write side of the FIFO
    output udp_echo_pkg::payload_beat_t wr_beat,
    output logic                        wr_valid,
    input  logic                        wr_ready
);
    import udp_echo_pkg::*;

    filter_state_t state;
    filter_state_t state_next;
    logic          port_match;
    logic          hdr_fire;
    logic          last_fire;

    assign port_match = (rx_hdr.dest_port == ECHO_PORT);

    // Only a filter between frames takes a header
    // A matching header waits for the reply side, others go straight away
    always_comb begin
        echo_hdr_valid = 1'b0;
        rx_hdr_ready   = 1'b0;
        if (state == FILTER_IDLE && rx_hdr_valid) begin
            if (port_match) begin
                echo_hdr_valid = 1'b1;
                rx_hdr_ready   = echo_hdr_ready;
            end else begin
                rx_hdr_ready = 1'b1;
            end
        end
    end

    // Payload gating, no added latency on the pass path
    always_comb begin
        wr_valid      = 1'b0;
        rx_beat_ready = 1'b0;
        case (state)
            FILTER_PASS: begin
                wr_valid      = rx_beat_valid;
                rx_beat_ready = wr_ready;
            end
            FILTER_DROP: begin
                rx_beat_ready = 1'b1;
            end
            default: begin
                wr_valid      = 1'b0;
                rx_beat_ready = 1'b0;
            end
        endcase
    end

    assign wr_beat = rx_beat;

    assign hdr_fire  = rx_hdr_valid && rx_hdr_ready;
    assign last_fire = rx_beat_valid && rx_beat_ready && rx_beat.last;

    always_comb begin
        state_next = state;
        case (state)
            FILTER_IDLE: begin
                if (hdr_fire) begin
                    state_next = port_match ? FILTER_PASS : FILTER_DROP;
                end
            end
            FILTER_PASS, FILTER_DROP: begin
                // Frame ends on the accepted last beat
                if (last_fire) begin
                    state_next = FILTER_IDLE;
                end
            end
            default: state_next = FILTER_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FILTER_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

/* udp_reply_builder.sv */
// Output side of the echo core: builds the reply header from the received one
// and keeps the first byte of each echoed frame on the LEDs.
`timescale 1ns/10ps

module udp_reply_builder (
    input  logic                         clk,
    input  logic                         rst,

    // Header from the port filter
    input  udp_echo_pkg::udp_rx_hdr_t    rx_hdr,
    input  logic                         echo_hdr_valid,
    output logic                         echo_hdr_ready,

    // Reply header out
    output udp_echo_pkg::udp_reply_hdr_t tx_hdr,
    output logic                         tx_hdr_valid,
    input  logic                         tx_hdr_ready,

    // Observed output payload stream
    input  udp_echo_pkg::payload_beat_t  rd_beat,
    input  logic                         rd_valid,
    input  logic                         rd_ready,

    output udp_echo_pkg::byte_t          led
);

    logic first_beat;
    logic beat_fire;

    // Reply goes back to the sender with the ports swapped
    always_comb begin
        tx_hdr.dest_ip     = rx_hdr.source_ip;
        tx_hdr.source_port = rx_hdr.dest_port;
        tx_hdr.dest_port   = rx_hdr.source_port;
        tx_hdr.length      = rx_hdr.length;
    end

    // Handshake passes straight through
    assign tx_hdr_valid   = echo_hdr_valid;
    assign echo_hdr_ready = tx_hdr_ready;

    assign beat_fire = rd_valid && rd_ready;

    // first_beat is set again by every last beat, so the next frame is captured
    always_ff @(posedge clk) begin
        if (rst) begin
            first_beat <= 1'b1;
            led        <= '0;
        end else if (beat_fire) begin
            if (first_beat) begin
                led <= rd_beat.data;
            end
            first_beat <= rd_beat.last;
        end
    end

endmodule
